// File: hdl/rv_isa_pkg.sv
// RV32I encodings and instruction field views, referenced by decode and the ALU stage
package rv_isa_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111, // FENCE, not supported
        OPC_SYSTEM   = 7'b1110011  // ECALL and EBREAK, not supported
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000, // ADD and SUB
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRX  = 3'b101, // SRL and SRA
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_func_e;

    // S and B immediates live in the funct7 and rd slots of r_fmt
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            opcode_e     opcode;
        } u_fmt;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            opcode_e     opcode;
        } j_fmt;
    } instr_u;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: hdl/core_pkg.sv
// Core-internal types: data width, register index and the bundles passed between stages
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC_DEFAULT = '0;

    // Fetch register contents seen by decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

    // Decoded command for the ALU stage
    typedef struct packed {
        logic                  valid;
        logic                  we;    // Register write, already cleared for x0
        reg_idx_t              rd;
        word_t                 op1;
        word_t                 op2;
        rv_isa_pkg::alu_func_e func;
        logic                  alt;   // SUB or SRA
    } exec_cmd_t;

    // Writeback record, also the retire port
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

// File: hdl/reg_file.sv
// Integer register file with two asynchronous read ports and the writeback port
`timescale 1ns/1ps

module reg_file (
    input  logic               ctrl_clk,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  core_pkg::retire_t  wr
);

    core_pkg::word_t regs [32];

    // x0 is hardwired
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge ctrl_clk) begin
        if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

// File: hdl/fetch_stage.sv
// Fetch stage: program counter, instruction cache address and the fetch register
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC_DEFAULT
) (
    input  logic             ctrl_clk,
    input  logic             ctrl_reset,
    input  logic             redirect,
    input  core_pkg::word_t  redirect_pc,
    output core_pkg::word_t  icache_addr,
    input  core_pkg::word_t  icache_data,
    input  logic             icache_rdy,
    output core_pkg::fetch_t fetched
);

    core_pkg::word_t pc;

    assign icache_addr = pc;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            pc            <= reset_pc;
            fetched.valid <= 1'b0;
        end else begin
            // A redirect is taken even while the cache stalls
            if (redirect) begin
                pc <= redirect_pc;
            end else if (icache_rdy) begin
                pc <= pc + 4;
            end

            if (icache_rdy) begin
                fetched.valid <= 1'b1;
                fetched.pc    <= pc;
                fetched.instr <= icache_data;
            end else begin
                fetched.valid <= 1'b0; // Bubble
            end
        end
    end

endmodule

// File: hdl/decode_stage.sv
// Decode stage: operand selection, immediates, branch and jump resolution, wrong-path squash
`timescale 1ns/1ps

module decode_stage (
    input  logic                ctrl_clk,
    input  logic                ctrl_reset,
    input  core_pkg::fetch_t    fetched,
    output core_pkg::reg_idx_t  rs1_idx,
    output core_pkg::reg_idx_t  rs2_idx,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output core_pkg::exec_cmd_t cmd
);

    rv_isa_pkg::instr_u  ins;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_u;
    core_pkg::word_t     imm_b;
    core_pkg::word_t     imm_j;
    core_pkg::word_t     jalr_sum;
    core_pkg::exec_cmd_t cmd_next;
    logic                squash;  // Instruction in the fetch register is wrong-path
    logic                live;
    logic                jump;
    logic                br_taken;
    logic                eq;
    logic                lt;
    logic                ltu;

    assign ins  = fetched.instr;
    assign live = fetched.valid && !squash;

    assign rs1_idx = ins.r_fmt.rs1;
    assign rs2_idx = ins.r_fmt.rs2;

    assign imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    assign imm_u = {ins.u_fmt.imm, 12'b0};
    assign imm_b = {{20{ins.r_fmt.funct7[6]}}, ins.r_fmt.rd[0], ins.r_fmt.funct7[5:0],
                    ins.r_fmt.rd[4:1], 1'b0};
    assign imm_j = {{12{ins.j_fmt.imm20}}, ins.j_fmt.imm19_12, ins.j_fmt.imm11,
                    ins.j_fmt.imm10_1, 1'b0};

    assign jalr_sum = rs1_data + imm_i;

    // Compare register values
    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        case (rv_isa_pkg::branch_func_e'(ins.r_fmt.funct3))
            rv_isa_pkg::BR_BEQ:  br_taken = eq;
            rv_isa_pkg::BR_BNE:  br_taken = !eq;
            rv_isa_pkg::BR_BLT:  br_taken = lt;
            rv_isa_pkg::BR_BGE:  br_taken = !lt;
            rv_isa_pkg::BR_BLTU: br_taken = ltu;
            rv_isa_pkg::BR_BGEU: br_taken = !ltu;
            default:             br_taken = 1'b0; // Reserved funct3
        endcase
    end

    always_comb begin
        cmd_next.valid = live;
        cmd_next.we    = 1'b0;
        cmd_next.rd    = ins.r_fmt.rd;
        cmd_next.op1   = rs1_data;
        cmd_next.op2   = rs2_data;
        cmd_next.func  = rv_isa_pkg::alu_func_e'(ins.r_fmt.funct3);
        cmd_next.alt   = 1'b0;
        jump           = 1'b0;
        redirect_pc    = fetched.pc + imm_b;

        case (ins.r_fmt.opcode)
            rv_isa_pkg::OPC_OP: begin
                cmd_next.we  = 1'b1;
                cmd_next.alt = ins.r_fmt.funct7[5];
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                cmd_next.we  = 1'b1;
                cmd_next.op2 = imm_i;
                // Only SRAI uses bit 30, otherwise it is immediate
                cmd_next.alt = (cmd_next.func == rv_isa_pkg::ALU_SRX) && ins.r_fmt.funct7[5];
            end
            rv_isa_pkg::OPC_LUI: begin
                cmd_next.we   = 1'b1;
                cmd_next.op1  = imm_u;
                cmd_next.op2  = '0;
                cmd_next.func = rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                cmd_next.we   = 1'b1;
                cmd_next.op1  = imm_u;
                cmd_next.op2  = fetched.pc;
                cmd_next.func = rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                cmd_next.we   = 1'b1;
                cmd_next.op1  = fetched.pc; // Link value
                cmd_next.op2  = 4;
                cmd_next.func = rv_isa_pkg::ALU_ADD;
                jump          = 1'b1;
                if (ins.r_fmt.opcode == rv_isa_pkg::OPC_JAL) begin
                    redirect_pc = fetched.pc + imm_j;
                end else begin
                    redirect_pc = {jalr_sum[core_pkg::XLEN-1:1], 1'b0};
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                jump = br_taken;
            end
            rv_isa_pkg::OPC_MISC_MEM, rv_isa_pkg::OPC_SYSTEM: begin
                cmd_next.we = 1'b0; // Known, retire nothing
            end
            default: begin
                cmd_next.we = 1'b0;
            end
        endcase

        if (cmd_next.rd == '0) begin
            cmd_next.we = 1'b0;
        end
    end

    assign redirect = live && jump;

    always_ff @(posedge ctrl_clk) begin
        cmd    <= cmd_next;
        squash <= redirect; // Next fetch register entry came from the old path
        if (ctrl_reset) begin
            cmd.valid <= 1'b0;
            cmd.we    <= 1'b0;
            squash    <= 1'b0;
        end
    end

endmodule

// File: hdl/alu_stage.sv
// Execute stage: integer ALU and the writeback register that drives the register file
`timescale 1ns/1ps

module alu_stage (
    input  logic                ctrl_clk,
    input  logic                ctrl_reset,
    input  core_pkg::exec_cmd_t cmd,
    output core_pkg::retire_t   retire
);

    core_pkg::word_t result;
    logic [4:0]      shamt;

    assign shamt = cmd.op2[4:0];

    always_comb begin
        result = '0;
        case (cmd.func)
            rv_isa_pkg::ALU_ADD: begin
                result = cmd.alt ? (cmd.op1 - cmd.op2) : (cmd.op1 + cmd.op2);
            end
            rv_isa_pkg::ALU_SLL: begin
                result = cmd.op1 << shamt;
            end
            rv_isa_pkg::ALU_SLT: begin
                result = {31'b0, $signed(cmd.op1) < $signed(cmd.op2)};
            end
            rv_isa_pkg::ALU_SLTU: begin
                result = {31'b0, cmd.op1 < cmd.op2};
            end
            rv_isa_pkg::ALU_XOR: begin
                result = cmd.op1 ^ cmd.op2;
            end
            rv_isa_pkg::ALU_SRX: begin
                if (cmd.alt) begin
                    result = core_pkg::word_t'($signed(cmd.op1) >>> shamt); // SRA
                end else begin
                    result = cmd.op1 >> shamt;
                end
            end
            rv_isa_pkg::ALU_OR: begin
                result = cmd.op1 | cmd.op2;
            end
            rv_isa_pkg::ALU_AND: begin
                result = cmd.op1 & cmd.op2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= cmd.valid && cmd.we; // Bubbles and non-writers drop here
            retire.rd    <= cmd.rd;
            retire.data  <= result;
        end
    end

endmodule

// File: hdl/rv_core.sv
// Top of the RV32I core; connects the pipeline stages, register file, icache and retire port
`timescale 1ns/1ps

module rv_core #(
    parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC_DEFAULT
) (
    input  logic              ctrl_clk,
    input  logic              ctrl_reset,
    output core_pkg::word_t   icache_addr,
    input  core_pkg::word_t   icache_data,
    input  logic              icache_rdy,
    output core_pkg::retire_t retire
);

    core_pkg::fetch_t    fetched;
    core_pkg::exec_cmd_t cmd;
    core_pkg::reg_idx_t  rs1_idx;
    core_pkg::reg_idx_t  rs2_idx;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                redirect;
    core_pkg::word_t     redirect_pc;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) i_fetch (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .icache_addr(icache_addr),
        .icache_data(icache_data),
        .icache_rdy (icache_rdy),
        .fetched    (fetched)
    );

    decode_stage i_decode (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .fetched    (fetched),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .cmd        (cmd)
    );

    alu_stage i_alu (
        .ctrl_clk  (ctrl_clk),
        .ctrl_reset(ctrl_reset),
        .cmd       (cmd),
        .retire    (retire)
    );

    // Written one cycle after retire shows on the port
    reg_file i_regs (
        .ctrl_clk(ctrl_clk),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr      (retire)
    );

endmodule

// File: include/tb_program.svh
// Test program for the core testbench; each row holds an instruction word and the retire it must give
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
    core_pkg::word_t   instr;
    core_pkg::retire_t result; // valid low for rows that never retire
} prog_row_t;

localparam int PROG_LEN = 47;

// Columns: instruction word, retires, rd, rd value
localparam prog_row_t PROG_TABLE [PROG_LEN] = '{
    {32'h00500093, 1'b1, 5'd1,  32'h00000005}, // 00 addi x1, x0, 5
    {32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD}, // 04 addi x2, x0, -3
    {32'h123451B7, 1'b1, 5'd3,  32'h12345000}, // 08 lui x3, 0x12345
    {32'h00001217, 1'b1, 5'd4,  32'h0000100C}, // 0c auipc x4, 0x1
    {32'h002082B3, 1'b1, 5'd5,  32'h00000002}, // 10 add x5, x1, x2
    {32'h40208333, 1'b1, 5'd6,  32'h00000008}, // 14 sub x6, x1, x2
    {32'h001123B3, 1'b1, 5'd7,  32'h00000001}, // 18 slt x7, x2, x1
    {32'h00113433, 1'b1, 5'd8,  32'h00000000}, // 1c sltu x8, x2, x1
    {32'h0020C4B3, 1'b1, 5'd9,  32'hFFFFFFF8}, // 20 xor x9, x1, x2
    {32'h0020E533, 1'b1, 5'd10, 32'hFFFFFFFD}, // 24 or x10, x1, x2
    {32'h0020F5B3, 1'b1, 5'd11, 32'h00000005}, // 28 and x11, x1, x2
    {32'h00111633, 1'b1, 5'd12, 32'hFFFFFFA0}, // 2c sll x12, x2, x1
    {32'h001156B3, 1'b1, 5'd13, 32'h07FFFFFF}, // 30 srl x13, x2, x1
    {32'h40115733, 1'b1, 5'd14, 32'hFFFFFFFF}, // 34 sra x14, x2, x1
    {32'h00108033, 1'b0, 5'd0,  32'h00000000}, // 38 add x0, x1, x1
    {32'hFFF12793, 1'b1, 5'd15, 32'h00000001}, // 3c slti x15, x2, -1
    {32'hFFF13813, 1'b1, 5'd16, 32'h00000001}, // 40 sltiu x16, x2, -1
    {32'h0F00C893, 1'b1, 5'd17, 32'h000000F5}, // 44 xori x17, x1, 0xf0
    {32'h7000E913, 1'b1, 5'd18, 32'h00000705}, // 48 ori x18, x1, 0x700
    {32'h0FF17993, 1'b1, 5'd19, 32'h000000FD}, // 4c andi x19, x2, 0xff
    {32'h00409A13, 1'b1, 5'd20, 32'h00000050}, // 50 slli x20, x1, 4
    {32'h01C15A93, 1'b1, 5'd21, 32'h0000000F}, // 54 srli x21, x2, 28
    {32'h40115B13, 1'b1, 5'd22, 32'hFFFFFFFE}, // 58 srai x22, x2, 1
    {32'h00208463, 1'b0, 5'd0,  32'h00000000}, // 5c beq x1, x2, +8 (not taken)
    {32'h00B08463, 1'b0, 5'd0,  32'h00000000}, // 60 beq x1, x11, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // 64 addi x31, x0, -1 (skipped)
    {32'h00B09463, 1'b0, 5'd0,  32'h00000000}, // 68 bne x1, x11, +8 (not taken)
    {32'h00209463, 1'b0, 5'd0,  32'h00000000}, // 6c bne x1, x2, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // 70 addi x31, x0, -1 (skipped)
    {32'h0020C463, 1'b0, 5'd0,  32'h00000000}, // 74 blt x1, x2, +8 (not taken)
    {32'h00114463, 1'b0, 5'd0,  32'h00000000}, // 78 blt x2, x1, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // 7c addi x31, x0, -1 (skipped)
    {32'h00115463, 1'b0, 5'd0,  32'h00000000}, // 80 bge x2, x1, +8 (not taken)
    {32'h0020D463, 1'b0, 5'd0,  32'h00000000}, // 84 bge x1, x2, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // 88 addi x31, x0, -1 (skipped)
    {32'h00116463, 1'b0, 5'd0,  32'h00000000}, // 8c bltu x2, x1, +8 (not taken)
    {32'h0020E463, 1'b0, 5'd0,  32'h00000000}, // 90 bltu x1, x2, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // 94 addi x31, x0, -1 (skipped)
    {32'h0020F463, 1'b0, 5'd0,  32'h00000000}, // 98 bgeu x1, x2, +8 (not taken)
    {32'h00117463, 1'b0, 5'd0,  32'h00000000}, // 9c bgeu x2, x1, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // a0 addi x31, x0, -1 (skipped)
    {32'h00800D6F, 1'b1, 5'd26, 32'h000000A8}, // a4 jal x26, +8
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // a8 addi x31, x0, -1 (skipped)
    {32'h064A0DE7, 1'b1, 5'd27, 32'h000000B0}, // ac jalr x27, 0x64(x20)
    {32'hFFF00F93, 1'b0, 5'd0,  32'h00000000}, // b0 addi x31, x0, -1 (skipped)
    {32'h001D0E33, 1'b1, 5'd28, 32'h000000AD}, // b4 add x28, x26, x1
    {32'hFFFFFE97, 1'b1, 5'd29, 32'hFFFFF0B8}  // b8 auipc x29, 0xfffff
};

`endif

// File: test/tb_rv_core.sv
// Testbench for rv_core; runs the program table once with steady and once with random icache ready
`timescale 1ns/1ps

module tb_rv_core;

    `include "tb_program.svh"

    localparam core_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 20;
    localparam int MAX_CYCLES   = 10 * PROG_LEN + 100; // Per pass

    logic              ctrl_clk;
    logic              ctrl_reset;
    core_pkg::word_t   icache_addr;
    core_pkg::word_t   icache_data;
    logic              icache_rdy = 1'b1;
    core_pkg::retire_t retire;

    core_pkg::retire_t exp_queue [$];
    int                mem_idx;
    bit                random_rdy  = 1'b0;
    bit                timed_out   = 1'b0;
    int                error_count = 0;
    int                check_count = 0;

    rv_core #(
        .reset_pc(RESET_PC)
    ) i_dut (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .icache_addr(icache_addr),
        .icache_data(icache_data),
        .icache_rdy (icache_rdy),
        .retire     (retire)
    );

    initial begin
        ctrl_clk = 1'b0;
        forever begin
            #20 ctrl_clk = ~ctrl_clk;
        end
    end

    // Instruction memory, NOPs past the end of the table
    assign mem_idx = int'(icache_addr >> 2);

    always_comb begin
        if (mem_idx >= 0 && mem_idx < PROG_LEN) begin
            icache_data = PROG_TABLE[mem_idx].instr;
        end else begin
            icache_data = rv_isa_pkg::NOP_WORD;
        end
    end

    always @(posedge ctrl_clk) begin
        if (random_rdy) begin
            icache_rdy <= ($urandom & 32'd1) != 32'd0; // Ready about half the time
        end else begin
            icache_rdy <= 1'b1;
        end
    end

    task automatic check_retire(input core_pkg::retire_t actual, input core_pkg::retire_t want);
        check_count++;
        if (actual !== want) begin
            $display("FAILED at %0t: retire x%0d = %08h, expected x%0d = %08h",
                     $time, actual.rd, actual.data, want.rd, want.data);
            error_count++;
        end
    endtask

    task automatic check_pc(input core_pkg::word_t actual, input core_pkg::word_t want);
        check_count++;
        if (actual !== want) begin
            $display("FAILED at %0t: icache_addr = %08h after reset, expected %08h",
                     $time, actual, want);
            error_count++;
        end
    endtask

    // Called on a rising edge, returns on a rising edge
    task automatic run_pass(input bit rdy_random);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        ctrl_reset <= 1'b1;
        random_rdy <= rdy_random;
        repeat (RESET_CYCLES) @(posedge ctrl_clk);
        ctrl_reset <= 1'b0;
        @(negedge ctrl_clk);
        check_pc(icache_addr, RESET_PC);

        while (seen < exp_queue.size() && cycles < MAX_CYCLES) begin
            if (retire.valid) begin
                check_retire(retire, exp_queue[seen]);
                seen++;
            end
            @(negedge ctrl_clk);
            cycles++;
        end

        if (seen < exp_queue.size()) begin
            $display("Timeout in pass %0d after %0d cycles, %0d of %0d retires missing",
                     rdy_random ? 2 : 1, cycles, exp_queue.size() - seen, exp_queue.size());
            error_count++;
            timed_out = 1'b1;
        end else begin
            repeat (DRAIN_CYCLES) begin
                @(negedge ctrl_clk);
                if (retire.valid) begin
                    $display("Extra retire of x%0d = %08h in pass %0d",
                             retire.rd, retire.data, rdy_random ? 2 : 1);
                    error_count++;
                end
            end
        end
        @(posedge ctrl_clk);
    endtask

    initial begin
        ctrl_reset = 1'b1;
        void'($urandom(32'hc2f7));
        for (int i = 0; i < PROG_LEN; i++) begin
            if (PROG_TABLE[i].result.valid) begin
                exp_queue.push_back(PROG_TABLE[i].result);
            end
        end

        run_pass(1'b0);
        if (!timed_out) begin
            run_pass(1'b1); // Same expected sequence under stalls
        end

        $display("Compared %0d values, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/alu_stage.sv
hdl/rv_core.sv
test/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_rv_core -f tb.f -o tb_rv_core

./obj_dir/tb_rv_core > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
